// ==== Makefile ====
# Build and run the array heap testbench with Verilator
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := arrayHeapTb
FILELIST  := flist.f
OBJ_DIR   := obj_dir
PASS_TEXT := >>> PASS
SOURCES   := $(wildcard src/*.sv src/*.svh verif/*.sv) $(FILELIST)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+src
src/arrayHeapPkg.sv
src/requestPort.sv
src/arrayAllocator.sv
src/arrayStore.sv
src/arrayScanner.sv
src/arrayHeap.sv
verif/requestPort_checker.sv
verif/arrayHeapTb.sv

// ==== src/arrayAllocator.sv ====
// Array allocation with a LIFO of freed arrays and a high-water mark
// Free returns the array number on success and zero on error
// Only Alloc and Free produce a done pulse here
`timescale 1ns/1ps

module arrayAllocator (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  start,
  input  arrayHeapPkg::actionT  cmdAction,
  input  arrayHeapPkg::arrayIdT cmdArray,
  output logic                  live,
  output logic                  clearSize,
  output arrayHeapPkg::arrayIdT clearArray,
  output logic                  allocDone,
  output arrayHeapPkg::dataT    allocResult,
  output arrayHeapPkg::errorT   allocError
);
  import arrayHeapPkg::*;

  typedef logic [$bits(arrayIdT):0] countT;  // 0 to ARRAYS

  arrayIdT           freeStack [ARRAYS];  // Freed arrays, top at freeTop-1
  countT             freeTop;             // Entries on the stack
  countT             highWater;           // Arrays ever handed out
  logic [ARRAYS-1:0] liveBits;            // One per array
  logic              isAlloc;
  logic              isFree;
  logic              fromStack;           // Reuse a freed array
  logic              fromFresh;           // Never-used array left
  logic              allocOk;
  logic              freeOk;
  arrayIdT           newArray;

  assign live      = liveBits[cmdArray];
  assign isAlloc   = start && (cmdAction == actAlloc);
  assign isFree    = start && (cmdAction == actFree);
  assign fromStack = (freeTop != '0);
  assign fromFresh = (highWater < ARRAYS);
  assign allocOk   = fromStack || fromFresh;
  assign freeOk    = live;                // Double free caught here
  assign newArray  = fromStack ? freeStack[arrayIdT'(freeTop - 1'b1)] : arrayIdT'(highWater);

  // Allocation state --------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freeTop   <= '0;
      highWater <= '0;
      liveBits  <= '0;
      clearSize <= 1'b0;
      allocDone <= 1'b0;
    end else begin
      allocDone <= isAlloc || isFree;
      clearSize <= isAlloc && allocOk;    // Store empties the new array
      if (isAlloc && allocOk) begin
        liveBits[newArray] <= 1'b1;
        if (fromStack) freeTop <= freeTop - 1'b1;
        else           highWater <= highWater + 1'b1;
      end
      if (isFree && freeOk) begin
        liveBits[cmdArray] <= 1'b0;
        freeTop            <= freeTop + 1'b1;
      end
    end
  end

  // Stack contents and results --------
  always_ff @(posedge clock) begin
    if (isFree && freeOk) freeStack[arrayIdT'(freeTop)] <= cmdArray;
    if (isAlloc) begin
      clearArray  <= newArray;
      allocResult <= allocOk ? dataT'(newArray) : '0;
      allocError  <= allocOk ? errNone : errOutOfMemory;
    end else if (isFree) begin
      allocResult <= freeOk ? dataT'(cmdArray) : '0;
      allocError  <= freeOk ? errNone : errNotAllocated;
    end
  end

endmodule

// ==== src/arrayHeap.sv ====
// Array heap top level behind a four-phase req/ack port
// One command at a time and scans take ARRAY_LENGTH extra cycles
`timescale 1ns/1ps

module arrayHeap (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  req,
  output logic                  ack,
  input  arrayHeapPkg::actionT  action,
  input  arrayHeapPkg::arrayIdT array,
  input  arrayHeapPkg::indexT   index,
  input  arrayHeapPkg::dataT    operand,
  output arrayHeapPkg::dataT    result,
  output arrayHeapPkg::errorT   error
);
  import arrayHeapPkg::*;

  // Captured command --------
  logic    start;
  actionT  cmdAction;
  arrayIdT cmdArray;
  indexT   cmdIndex;
  dataT    cmdOperand;

  // Allocator --------
  logic    live;
  logic    clearSize;
  arrayIdT clearArray;
  logic    allocDone;
  dataT    allocResult;
  errorT   allocError;

  // Store and scanner --------
  logic    storeDone;
  dataT    storeResult;
  errorT   storeError;
  logic    scanStart;
  actionT  scanAction;
  dataT    scanOperand;
  sizeT    scanSize;
  dataT    scanElement;
  indexT   scanIndex;
  logic    scanDone;
  dataT    scanCount;

  requestPort port0 (.*);         // Handshake and command capture

  arrayAllocator allocator0 (.*); // Alloc and Free

  arrayStore store0 (.*);         // Element commands

  arrayScanner scanner0 (.*);     // Index, Less and Greater

endmodule

// ==== src/arrayHeapPkg.sv ====
// Types shared by the array heap and its testbench
// Enum encodings are fixed so that a requester can drive them as plain bits
`include "arrayHeap_cfg.svh"

package arrayHeapPkg;

  // Geometry --------------
  localparam int ARRAYS       = 1 << `ARRAY_HEAP_ADDRESS_BITS;  // Arrays in the heap
  localparam int ARRAY_LENGTH = 1 << `ARRAY_HEAP_INDEX_BITS;    // Elements per array

  typedef logic [`ARRAY_HEAP_ADDRESS_BITS-1:0] arrayIdT;  // Array number
  typedef logic [`ARRAY_HEAP_INDEX_BITS-1:0]   indexT;    // Element position
  typedef logic [`ARRAY_HEAP_INDEX_BITS:0]     sizeT;     // 0 to ARRAY_LENGTH
  typedef logic [`ARRAY_HEAP_DATA_BITS-1:0]    dataT;     // Element, operand or result

  // Commands --------------
  typedef enum logic [3:0] {
    actAlloc   = 4'd0,  // Take a free array
    actFree    = 4'd1,  // Return an array
    actWrite   = 4'd2,  // Store at index
    actRead    = 4'd3,  // Load from index
    actSize    = 4'd4,  // Current size
    actPush    = 4'd5,  // Append
    actPop     = 4'd6,  // Remove last
    actIndex   = 4'd7,  // Last match plus one
    actLess    = 4'd8,  // Count below operand
    actGreater = 4'd9   // Count above operand
  } actionT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,  // Array not live
    errOutOfBounds  = 3'd2,  // Read at or past size
    errFull         = 3'd3,  // Push on full array
    errEmpty        = 3'd4,  // Pop on empty array
    errOutOfMemory  = 3'd5   // No array left to allocate
  } errorT;

endpackage

// ==== src/arrayHeap_cfg.svh ====
// Size settings for the array heap
// Array count and array length are powers of two of these widths
// Data bits must be at least index bits plus one so that a size fits in a result
`ifndef ARRAY_HEAP_CFG_SVH
`define ARRAY_HEAP_CFG_SVH

// Heap geometry --------
`define ARRAY_HEAP_ADDRESS_BITS 2    // Bits in an array number
`define ARRAY_HEAP_INDEX_BITS   3    // Bits in an element index

// Payload --------
`define ARRAY_HEAP_DATA_BITS    12   // Bits in one element

`endif

// ==== src/arrayScanner.sv ====
// Sequential scan for Index, Less and Greater
// Visits every element position once per cycle and counts only those below scanSize
// Inputs from the store stay stable for the whole scan
`timescale 1ns/1ps

module arrayScanner (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 scanStart,
  input  arrayHeapPkg::actionT scanAction,
  input  arrayHeapPkg::dataT   scanOperand,
  input  arrayHeapPkg::sizeT   scanSize,
  input  arrayHeapPkg::dataT   scanElement,
  output arrayHeapPkg::indexT  scanIndex,
  output logic                 scanDone,
  output arrayHeapPkg::dataT   scanCount
);
  import arrayHeapPkg::*;

  logic running;    // Positions 1 onwards
  logic active;     // Examining an element this cycle
  logic inRange;    // Position below size
  logic match;
  dataT base;       // Accumulator before this element
  dataT nextCount;

  assign active  = scanStart || running;             // Position 0 is seen with scanStart
  assign inRange = {1'b0, scanIndex} < scanSize;
  assign base    = scanStart ? '0 : scanCount;

  // Element compare --------
  always_comb begin
    case (scanAction)
      actIndex:   match = (scanElement == scanOperand);
      actLess:    match = (scanElement < scanOperand);
      actGreater: match = (scanElement > scanOperand);
      default:    match = 1'b0;
    endcase
  end

  always_comb begin
    nextCount = base;
    if (inRange && match) begin
      if (scanAction == actIndex) nextCount = dataT'(scanIndex) + 1'b1;  // Last match plus one
      else                        nextCount = base + 1'b1;
    end
  end

  // Position counter --------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      running   <= 1'b0;
      scanIndex <= '0;
      scanDone  <= 1'b0;
    end else begin
      scanDone <= active && (&scanIndex);             // Last position examined
      if (active) begin
        scanIndex <= scanIndex + 1'b1;                // Wraps back to 0
        running   <= ~(&scanIndex);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (active) scanCount <= nextCount;               // Held until the next scan
  end

endmodule

// ==== src/arrayStore.sv ====
// Element memory and per-array sizes
// Handles Write, Read, Size, Push and Pop and hands scans on to the scanner
// Results are zero on error and sizes are zero-extended into the result
`timescale 1ns/1ps

module arrayStore (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  start,
  input  arrayHeapPkg::actionT  cmdAction,
  input  arrayHeapPkg::arrayIdT cmdArray,
  input  arrayHeapPkg::indexT   cmdIndex,
  input  arrayHeapPkg::dataT    cmdOperand,
  input  logic                  live,
  input  logic                  clearSize,
  input  arrayHeapPkg::arrayIdT clearArray,
  input  arrayHeapPkg::indexT   scanIndex,
  output logic                  storeDone,
  output arrayHeapPkg::dataT    storeResult,
  output arrayHeapPkg::errorT   storeError,
  output logic                  scanStart,
  output arrayHeapPkg::actionT  scanAction,
  output arrayHeapPkg::dataT    scanOperand,
  output arrayHeapPkg::sizeT    scanSize,
  output arrayHeapPkg::dataT    scanElement
);
  import arrayHeapPkg::*;

  dataT    memory [ARRAYS][ARRAY_LENGTH];  // Fixed block per array
  sizeT    sizes  [ARRAYS];                // Live elements per array
  arrayIdT scanArray;                      // Array under scan
  sizeT    size;                           // Size of cmdArray
  indexT   last;                           // Top element position
  logic    isScan;
  logic    isElement;
  logic    inBounds;
  logic    hasRoom;
  logic    nonEmpty;
  dataT    nextResult;
  errorT   nextError;

  assign size        = sizes[cmdArray];
  assign last        = indexT'(size - 1'b1);
  assign inBounds    = {1'b0, cmdIndex} < size;
  assign hasRoom     = size < ARRAY_LENGTH;
  assign nonEmpty    = size != '0;
  assign isScan      = cmdAction inside {actIndex, actLess, actGreater};
  assign isElement   = cmdAction inside {actWrite, actRead, actSize, actPush, actPop};
  assign scanElement = memory[scanArray][scanIndex];  // Scanner reads one per cycle

  // Result of an element command --------
  always_comb begin
    nextResult = '0;
    nextError  = errNone;
    if (!live) begin
      nextError = errNotAllocated;
    end else begin
      case (cmdAction)
        actWrite: nextResult = cmdOperand;
        actRead: begin
          if (inBounds) nextResult = memory[cmdArray][cmdIndex];
          else          nextError  = errOutOfBounds;
        end
        actSize: nextResult = dataT'(size);
        actPush: begin
          if (hasRoom) nextResult = cmdOperand;
          else         nextError  = errFull;
        end
        actPop: begin
          if (nonEmpty) nextResult = memory[cmdArray][last];
          else          nextError  = errEmpty;
        end
        default: nextResult = '0;
      endcase
    end
  end

  // Sizes and control pulses --------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < ARRAYS; a++) begin
        sizes[a] <= '0;
      end
      storeDone <= 1'b0;
      scanStart <= 1'b0;
    end else begin
      storeDone <= start && (isElement || (isScan && !live));  // Failed scans end here
      scanStart <= start && isScan && live;
      if (clearSize) begin
        sizes[clearArray] <= '0;                               // Fresh allocation
      end else if (start && live) begin
        case (cmdAction)
          actWrite: if (!inBounds) sizes[cmdArray] <= sizeT'(cmdIndex) + 1'b1;
          actPush:  if (hasRoom)   sizes[cmdArray] <= size + 1'b1;
          actPop:   if (nonEmpty)  sizes[cmdArray] <= size - 1'b1;
          default:  ;
        endcase
      end
    end
  end

  // Element memory and payload --------
  always_ff @(posedge clock) begin
    if (start && live && (cmdAction == actWrite)) memory[cmdArray][cmdIndex] <= cmdOperand;
    if (start && live && (cmdAction == actPush) && hasRoom) begin
      memory[cmdArray][indexT'(size)] <= cmdOperand;           // Append at size
    end
    if (start) begin
      storeResult <= nextResult;
      storeError  <= nextError;                                // Scans use it on failure
    end
    if (start && isScan) begin
      scanAction  <= cmdAction;
      scanOperand <= cmdOperand;
      scanSize    <= size;
      scanArray   <= cmdArray;
    end
  end

endmodule

// ==== src/requestPort.sv ====
// Four-phase req/ack front end with one command in flight at a time
// The requester holds action, array, index and operand stable while req is high
// Result and error are held from the rise of ack until the next command completes
`timescale 1ns/1ps

module requestPort (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  req,
  input  arrayHeapPkg::actionT  action,
  input  arrayHeapPkg::arrayIdT array,
  input  arrayHeapPkg::indexT   index,
  input  arrayHeapPkg::dataT    operand,
  input  logic                  allocDone,
  input  logic                  storeDone,
  input  logic                  scanDone,
  input  arrayHeapPkg::dataT    allocResult,
  input  arrayHeapPkg::dataT    storeResult,
  input  arrayHeapPkg::dataT    scanCount,
  input  arrayHeapPkg::errorT   allocError,
  input  arrayHeapPkg::errorT   storeError,
  output logic                  ack,
  output arrayHeapPkg::dataT    result,
  output arrayHeapPkg::errorT   error,
  output logic                  start,
  output arrayHeapPkg::actionT  cmdAction,
  output arrayHeapPkg::arrayIdT cmdArray,
  output arrayHeapPkg::indexT   cmdIndex,
  output arrayHeapPkg::dataT    cmdOperand
);
  import arrayHeapPkg::*;

  typedef enum logic [1:0] {stateIdle, stateBusy, stateAcked} stateT;

  stateT state;   // Handshake FSM
  logic  accept;  // New command taken this cycle
  logic  done;    // Any back end finished

  assign accept = (state == stateIdle) && req;
  assign done   = allocDone || storeDone || scanDone;

  // Handshake FSM --------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= stateIdle;
      start <= 1'b0;
      ack   <= 1'b0;
    end else begin
      start <= accept;                  // One cycle pulse after req seen
      case (state)
        stateIdle: begin
          if (req) state <= stateBusy;
        end
        stateBusy: begin
          if (done) begin
            ack   <= 1'b1;              // Registered after the done pulse
            state <= stateAcked;
          end
        end
        stateAcked: begin
          if (!req) begin               // Requester released
            ack   <= 1'b0;
            state <= stateIdle;
          end
        end
        default: state <= stateIdle;
      endcase
    end
  end

  // Command and result --------
  always_ff @(posedge clock) begin
    if (accept) begin
      cmdAction  <= action;
      cmdArray   <= array;
      cmdIndex   <= index;
      cmdOperand <= operand;
    end
    if (state == stateBusy) begin       // Exactly one done per start
      if (allocDone) begin
        result <= allocResult;
        error  <= allocError;
      end else if (storeDone) begin
        result <= storeResult;
        error  <= storeError;
      end else if (scanDone) begin
        result <= scanCount;
        error  <= errNone;              // Scans only fail in the store
      end
    end
  end

endmodule

// ==== verif/arrayHeapTb.sv ====
// Directed and random testbench for the array heap with a reference model
// Stops at the first mismatch and the watchdog bounds the run by the command count
// Memory is filled before any read so that every element value is known
`timescale 1ns/1ps

module arrayHeapTb;
  import arrayHeapPkg::*;

  localparam int PERIOD        = 40;                 // ns
  localparam int RESET_CYCLES  = 5;
  localparam int RANDOM_CMDS   = 400;
  localparam int DIRECTED_CMDS = 100;                // Upper bound for directed part
  localparam int CMD_CYCLES    = ARRAY_LENGTH + 6;   // Worst case per command
  localparam int DATA_RANGE    = 1 << $bits(dataT);

  logic    clock;
  logic    resetN;
  logic    req;
  logic    ack;
  actionT  action;
  arrayIdT array;
  indexT   index;
  dataT    operand;
  dataT    result;
  errorT   error;
  integer  seed;

  // Reference model --------------------
  dataT modelMem  [ARRAYS][ARRAY_LENGTH];
  int   modelSize [ARRAYS];
  bit   modelLive [ARRAYS];
  int   freeList  [$];                               // Back is the top
  int   highWater;                                   // Arrays ever handed out

  arrayHeap dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  function automatic int randomBelow(input int limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  task automatic checkValue(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Element and scan rules on a live array
  task automatic applyElement(input actionT a, input int arr, input int idx, input dataT opd,
                              output dataT expResult, output errorT expError);
    int last;
    int count;
    last      = 0;
    count     = 0;
    expResult = '0;
    expError  = errNone;
    case (a)
      actWrite: begin
        modelMem[arr][idx] = opd;
        if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;  // Grow past the end
        expResult = opd;
      end
      actRead: begin
        if (idx < modelSize[arr]) expResult = modelMem[arr][idx];
        else                      expError  = errOutOfBounds;
      end
      actSize: expResult = dataT'(modelSize[arr]);
      actPush: begin
        if (modelSize[arr] < ARRAY_LENGTH) begin
          modelMem[arr][modelSize[arr]] = opd;
          modelSize[arr]++;
          expResult = opd;
        end else begin
          expError = errFull;
        end
      end
      actPop: begin
        if (modelSize[arr] > 0) begin
          modelSize[arr]--;
          expResult = modelMem[arr][modelSize[arr]];
        end else begin
          expError = errEmpty;
        end
      end
      default: begin                                  // Index, Less, Greater
        for (int p = 0; p < modelSize[arr]; p++) begin
          if (a == actIndex && modelMem[arr][p] == opd) last = p + 1;
          if (a == actLess && modelMem[arr][p] < opd) count++;
          if (a == actGreater && modelMem[arr][p] > opd) count++;
        end
        expResult = dataT'((a == actIndex) ? last : count);
      end
    endcase
  endtask

  task automatic predict(input actionT a, input int arr, input int idx, input dataT opd,
                         output dataT expResult, output errorT expError);
    int n;
    n         = -1;
    expResult = '0;
    expError  = errNone;
    if (a == actAlloc) begin
      if (freeList.size() > 0) begin
        n = freeList.pop_back();                      // LIFO reuse
      end else if (highWater < ARRAYS) begin
        n = highWater;
        highWater++;
      end
      if (n < 0) begin
        expError = errOutOfMemory;
      end else begin
        modelLive[n] = 1'b1;
        modelSize[n] = 0;
        expResult    = dataT'(n);
      end
    end else if (!modelLive[arr]) begin
      expError = errNotAllocated;                     // Includes double Free
    end else if (a == actFree) begin
      modelLive[arr] = 1'b0;
      freeList.push_back(arr);
      expResult = dataT'(arr);
    end else begin
      applyElement(a, arr, idx, opd, expResult, expError);
    end
  endtask

  // One four-phase transaction, entered and left on a falling edge
  task automatic runCommand(input actionT a, input int arr, input int idx, input int opd);
    dataT  expResult;
    errorT expError;
    predict(a, arr, idx, dataT'(opd), expResult, expError);
    action  = a;
    array   = arrayIdT'(arr);
    index   = indexT'(idx);
    operand = dataT'(opd);
    req     = 1'b1;
    while (ack !== 1'b1) @(negedge clock);
    checkValue($sformatf("result of %s", a.name()), int'(result), int'(expResult));
    checkValue($sformatf("error of %s", a.name()), int'(error), int'(expError));
    repeat (randomBelow(3)) @(negedge clock);         // Requester delay
    req = 1'b0;
    while (ack !== 1'b0) @(negedge clock);
  endtask

  // Watchdog --------------------
  initial begin
    #((DIRECTED_CMDS + RANDOM_CMDS) * CMD_CYCLES * PERIOD + RESET_CYCLES * PERIOD);
    $display("Timeout: the DUT stopped answering requests");
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

  // Stimulus --------------------
  initial begin
    int act;
    int arr;
    seed      = 37;
    highWater = 0;
    resetN    = 1'b0;
    req       = 1'b0;
    action    = actAlloc;
    array     = '0;
    index     = '0;
    operand   = '0;
    for (int a = 0; a < ARRAYS; a++) begin
      modelSize[a] = 0;
      modelLive[a] = 1'b0;
    end
    repeat (RESET_CYCLES) @(negedge clock);
    resetN = 1'b1;
    @(negedge clock);

    // Allocation order, exhaustion and LIFO reuse
    runCommand(actRead, 1, 0, 0);                     // Never allocated
    for (int a = 0; a <= ARRAYS; a++) runCommand(actAlloc, 0, 0, 0);  // Last one fails
    for (int a = 0; a < ARRAYS; a++) begin
      for (int p = 0; p < ARRAY_LENGTH; p++) runCommand(actWrite, a, p, randomBelow(DATA_RANGE));
    end
    runCommand(actFree, 2, 0, 0);
    runCommand(actFree, 0, 0, 0);
    runCommand(actAlloc, 0, 0, 0);                    // 0 comes back first
    runCommand(actAlloc, 0, 0, 0);

    // Write, Read and bounds on array 0
    runCommand(actWrite, 0, 5, randomBelow(DATA_RANGE));
    runCommand(actSize, 0, 0, 0);
    runCommand(actRead, 0, 5, 0);
    runCommand(actRead, 0, 6, 0);                     // At the size
    runCommand(actRead, 0, 3, 0);                     // Old contents

    // Stack use on array 2
    runCommand(actPop, 2, 0, 0);
    for (int p = 0; p <= ARRAY_LENGTH; p++) runCommand(actPush, 2, 0, randomBelow(DATA_RANGE));
    for (int p = 0; p <= ARRAY_LENGTH; p++) runCommand(actPop, 2, 0, 0);

    // Scans on array 1 with elements past the size
    for (int p = 0; p < 3; p++) runCommand(actPop, 1, 0, 0);
    runCommand(actIndex, 1, 0, modelMem[1][2]);
    runCommand(actIndex, 1, 0, modelMem[1][6]);       // Past the size
    runCommand(actLess, 1, 0, modelMem[1][1]);
    runCommand(actGreater, 1, 0, modelMem[1][3]);
    runCommand(actLess, 1, 0, 0);                     // Nothing below zero
    runCommand(actGreater, 1, 0, DATA_RANGE - 1);

    // Commands on a freed array
    runCommand(actFree, 3, 0, 0);
    for (int c = actWrite; c <= actGreater; c++) runCommand(actionT'(c), 3, 1, 7);
    runCommand(actFree, 3, 0, 0);                     // Double free
    runCommand(actAlloc, 0, 0, 0);

    // Random mix
    for (int n = 0; n < RANDOM_CMDS; n++) begin
      act = randomBelow(10);
      arr = randomBelow(ARRAYS);
      if (randomBelow(2) == 0) begin                  // Stored value for scan hits
        runCommand(actionT'(act), arr, randomBelow(ARRAY_LENGTH),
                   modelMem[arr][randomBelow(ARRAY_LENGTH)]);
      end else begin
        runCommand(actionT'(act), arr, randomBelow(ARRAY_LENGTH), randomBelow(DATA_RANGE));
      end
    end

    if (dut0.port0.handshakeCheck0.failures == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Handshake assertions failed during the run");
      $display(">>> FAIL");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

// ==== verif/requestPort_checker.sv ====
// Handshake assertions, bound into every requestPort instance
// Sampled on the rising clock edge and idle while reset is low
`timescale 1ns/1ps

module requestPortChecker (
  input logic                clock,
  input logic                resetN,
  input logic                req,
  input logic                ack,
  input logic                start,
  input arrayHeapPkg::dataT  result,
  input arrayHeapPkg::errorT error
);
  int failures = 0;  // Read by the testbench at the end

  ackNeedsReq: assert property (@(posedge clock) disable iff (!resetN)
    (!req && !ack) |=> !ack)               // No ack without a request
    else begin
      failures++;
      $error("ack rose while req was low");
    end

  resultHeld: assert property (@(posedge clock) disable iff (!resetN)
    (ack && $past(ack)) |-> ($stable(result) && $stable(error)))
    else begin
      failures++;
      $error("result or error changed while ack was high");
    end

  startFromIdle: assert property (@(posedge clock) disable iff (!resetN)
    start |-> $past(req && !ack))          // No new command while acked
    else begin
      failures++;
      $error("start pulsed while a command was still in flight");
    end

endmodule

bind requestPort requestPortChecker handshakeCheck0 (.*);
